//--- dmem_consts.svh
// Widths, write-buffer depth, uncached region base and testbench timeouts, included where needed.
`ifndef DMEM_CONSTS_SVH
`define DMEM_CONSTS_SVH

// Address and data widths of the core port and the memory bus.
`define DMEM_ADDR_W 32
`define DMEM_DATA_W 32

// Number of posted write entries held in front of the bus.
`define DMEM_WB_DEPTH 4

// Addresses at or above this base bypass the write buffer.
`define DMEM_UNCACHED_BASE 32'h8000_0000

// Upper bound in cycles for any single handshake wait in the testbench.
`define DMEM_TIMEOUT 200

`endif

//--- cpu_port_pkg.sv
// Core-side load/store request and response types, imported by the alignment unit and its users.
`include "dmem_consts.svh"

package cpu_port_pkg;

	// Byte address and data word as seen by the load/store stage.
	typedef logic [`DMEM_ADDR_W-1:0] addr_t;
	typedef logic [`DMEM_DATA_W-1:0] data_t;

	// Access width requested by the load/store stage.
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} access_size_e;

	// One load or store from the core. The core holds it until ready.
	typedef struct packed {
		logic         rw;          // 1 for a store.
		access_size_e size;
		logic         is_unsigned; // Zero-extend subword loads.
		addr_t        address;     // Byte address.
		data_t        wdata;       // Store data, right aligned.
	} lsu_req_t;

	// Load data back to the core, already extended.
	typedef struct packed {
		data_t rdata;
	} lsu_rsp_t;

endpackage

//--- mem_bus_pkg.sv
// Memory-bus request types and the word-level link between the alignment unit and the write buffer.
`include "dmem_consts.svh"

package mem_bus_pkg;

	// Every bus transfer moves one full word; there are no byte strobes.
	typedef logic [`DMEM_DATA_W-1:0] bus_word_t;

	// Request payload on the shared memory bus.
	typedef struct packed {
		logic      rw;      // 1 for a write.
		bus_word_t address; // Word aligned.
		bus_word_t wdata;
	} bus_req_t;

	// Word request from the alignment unit, tagged with its region.
	typedef struct packed {
		bus_req_t req;
		logic     cached;   // Write may be posted in the buffer.
	} word_req_t;

endpackage

//--- dmem_access_align.sv
// Alignment unit that maps core loads and stores onto word accesses; instantiated by dmem_subsystem.
`timescale 1ns/1ps
`include "dmem_consts.svh"

module dmem_access_align (
	input  logic                   i_clock,
	input  logic                   i_rst_n,

	// Core load/store port.
	input  logic                   i_lsu_request,
	input  cpu_port_pkg::lsu_req_t i_lsu_req,
	output logic                   o_lsu_ready,
	output cpu_port_pkg::lsu_rsp_t o_lsu_rsp,

	// Word port towards the write buffer.
	output logic                   o_word_request,
	output mem_bus_pkg::word_req_t o_word_req,
	input  logic                   i_word_ready,
	input  mem_bus_pkg::bus_word_t i_word_rdata
);
	import cpu_port_pkg::*;
	import mem_bus_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		RMW_READ,
		RMW_WRITE
	} align_state_e;

	align_state_e state, next_state;

	logic      subword_store;
	logic      is_cached;
	bus_word_t word_address;
	bus_word_t merged_word;     // Read word with the store lane patched in.
	bus_word_t rmw_word;        // Merged word held for the write phase.
	data_t     byte_lane;
	data_t     half_lane;
	data_t     load_data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Address and region decode.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign subword_store = i_lsu_req.rw && (i_lsu_req.size != SIZE_WORD);
	assign word_address  = {i_lsu_req.address[`DMEM_ADDR_W-1:2], 2'b00};
	assign is_cached     = (i_lsu_req.address < `DMEM_UNCACHED_BASE);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Load lane extraction and store lane merge.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign byte_lane = i_word_rdata >> {i_lsu_req.address[1:0], 3'b000};
	assign half_lane = i_word_rdata >> {i_lsu_req.address[1], 4'b0000};

	always_comb begin
		unique case (i_lsu_req.size)
			SIZE_BYTE: load_data = i_lsu_req.is_unsigned ? {24'b0, byte_lane[7:0]} :
				{{24{byte_lane[7]}}, byte_lane[7:0]};
			SIZE_HALF: load_data = i_lsu_req.is_unsigned ? {16'b0, half_lane[15:0]} :
				{{16{half_lane[15]}}, half_lane[15:0]};
			default:   load_data = i_word_rdata;
		endcase
	end

	assign o_lsu_rsp.rdata = load_data; // Only meaningful while o_lsu_ready is high.

	always_comb begin
		merged_word = i_word_rdata;
		if (i_lsu_req.size == SIZE_BYTE) begin
			merged_word[{i_lsu_req.address[1:0], 3'b000} +: 8] = i_lsu_req.wdata[7:0];
		end
		else begin
			merged_word[{i_lsu_req.address[1], 4'b0000} +: 16] = i_lsu_req.wdata[15:0];
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read-modify-write sequencing.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		next_state              = state;
		o_word_request          = 1'b0;
		o_word_req.req.rw       = i_lsu_req.rw;
		o_word_req.req.address  = word_address;
		o_word_req.req.wdata    = i_lsu_req.wdata;
		o_word_req.cached       = is_cached;
		o_lsu_ready             = 1'b0;

		unique case (state)
			IDLE: begin
				if (i_lsu_request && subword_store) begin
					next_state = RMW_READ; // Nothing goes out this cycle.
				end
				else begin
					o_word_request = i_lsu_request;
					o_lsu_ready    = i_lsu_request && i_word_ready;
				end
			end
			RMW_READ: begin
				o_word_request    = 1'b1;
				o_word_req.req.rw = 1'b0;
				if (i_word_ready) begin
					next_state = RMW_WRITE;
				end
			end
			RMW_WRITE: begin
				o_word_request       = 1'b1;
				o_word_req.req.rw    = 1'b1;
				o_word_req.req.wdata = rmw_word;
				if (i_word_ready) begin
					o_lsu_ready = 1'b1;  // The store retires with the write.
					next_state  = IDLE;
				end
			end
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= IDLE;
		end
		else begin
			state <= next_state;
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == RMW_READ && i_word_ready) begin
			rmw_word <= merged_word;
		end
	end

	// The merge and the write address are taken from the live core request.
	a_core_req_stable: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(state != IDLE) |-> (i_lsu_request && $stable(i_lsu_req)))
		else $error("Core request changed during a read-modify-write.");

endmodule

//--- dcache_write_buffer.sv
// Posted write buffer between the alignment unit and the memory bus; instantiated by dmem_subsystem.
`timescale 1ns/1ps
`include "dmem_consts.svh"

module dcache_write_buffer (
	input  logic                   i_clock,
	input  logic                   i_rst_n,

	// Word port from the alignment unit.
	input  logic                   i_word_request,
	input  mem_bus_pkg::word_req_t i_word_req,
	output logic                   o_word_ready,
	output mem_bus_pkg::bus_word_t o_word_rdata,

	// Memory bus.
	output logic                   o_bus_request,
	output mem_bus_pkg::bus_req_t  o_bus_req,
	input  logic                   i_bus_ready,
	input  mem_bus_pkg::bus_word_t i_bus_rdata
);
	import mem_bus_pkg::*;

	localparam int DEPTH = `DMEM_WB_DEPTH;
	localparam int IDX_W = $clog2(DEPTH);

	// Valid entries always fill slots from zero upward, so slot 0 is the oldest.
	logic [DEPTH-1:0] wb_valid;
	logic [DEPTH-1:0] next_valid;
	bus_word_t        wb_address [DEPTH];
	bus_word_t        wb_data    [DEPTH];

	logic             wb_empty;
	logic             wb_full;
	logic             is_posted;     // Request is a cacheable write.
	logic             post_write;    // A cacheable write is taken this cycle.
	logic             pass_through;  // Request goes straight to the bus.
	logic             drain_done;    // Oldest entry leaves this cycle.
	logic [IDX_W-1:0] free_idx;
	logic [IDX_W-1:0] write_idx;
	bus_req_t         drain_req;

	assign wb_empty = !wb_valid[0];
	assign wb_full  = wb_valid[DEPTH-1];

	assign is_posted    = i_word_req.req.rw && i_word_req.cached;
	assign post_write   = i_word_request && is_posted && !wb_full;
	assign pass_through = i_word_request && !is_posted && wb_empty;
	assign drain_done   = !wb_empty && i_bus_ready;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Slot selection.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Lowest free slot. Not used when the buffer is full.
	always_comb begin
		free_idx = '0;
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (!wb_valid[i]) begin
				free_idx = IDX_W'(i);
			end
		end
	end

	// A drain in the same cycle shifts everything down by one slot.
	assign write_idx = drain_done ? free_idx - 1'b1 : free_idx;

	always_comb begin
		next_valid = drain_done ? (wb_valid >> 1) : wb_valid;
		if (post_write) begin
			next_valid[write_idx] = 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus side and word-port answer.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign drain_req.rw      = 1'b1;
	assign drain_req.address = wb_address[0];
	assign drain_req.wdata   = wb_data[0];

	// Pending entries own the bus; other requests wait until they are gone.
	assign o_bus_request = !wb_empty || pass_through;
	assign o_bus_req     = wb_empty ? i_word_req.req : drain_req;

	assign o_word_ready = post_write || (pass_through && i_bus_ready);
	assign o_word_rdata = i_bus_rdata;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Entry storage.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wb_valid <= '0;
		end
		else begin
			wb_valid <= next_valid;
		end
	end

	always_ff @(posedge i_clock) begin
		if (drain_done) begin
			for (int i = 0; i < DEPTH - 1; i++) begin
				wb_address[i] <= wb_address[i + 1];
				wb_data[i]    <= wb_data[i + 1];
			end
		end
		// The new entry overrides the shifted value in its slot.
		if (post_write) begin
			wb_address[write_idx] <= i_word_req.req.address;
			wb_data[write_idx]    <= i_word_req.req.wdata;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Holds for drains here and for pass-through traffic held by the alignment unit.
	a_bus_stable: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(o_bus_request && !i_bus_ready) |=> (o_bus_request && $stable(o_bus_req)))
		else $error("Bus request dropped or changed before ready.");

	// A posted write adds exactly one entry and never lands on a valid slot.
	a_post_adds_entry: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		post_write |=> ($countones(wb_valid) ==
			$countones($past(wb_valid)) + 1 - int'($past(drain_done))))
		else $error("Posted write overwrote a buffer entry.");

endmodule

//--- dmem_subsystem.sv
// Data-memory path top level joining the alignment unit and the write buffer; the testbench DUT.
`timescale 1ns/1ps

module dmem_subsystem (
	input  logic                   i_clock,
	input  logic                   i_rst_n,

	// Core load/store port.
	input  logic                   i_lsu_request,
	input  cpu_port_pkg::lsu_req_t i_lsu_req,
	output logic                   o_lsu_ready,
	output cpu_port_pkg::lsu_rsp_t o_lsu_rsp,

	// Shared memory bus.
	output logic                   o_bus_request,
	output mem_bus_pkg::bus_req_t  o_bus_req,
	input  logic                   i_bus_ready,
	input  mem_bus_pkg::bus_word_t i_bus_rdata
);
	import mem_bus_pkg::*;

	// Word-level link between the two stages.
	logic      word_request;
	word_req_t word_req;
	logic      word_ready;
	bus_word_t word_rdata;

	dmem_access_align align0 (
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_lsu_request  (i_lsu_request),
		.i_lsu_req      (i_lsu_req),
		.o_lsu_ready    (o_lsu_ready),
		.o_lsu_rsp      (o_lsu_rsp),
		.o_word_request (word_request),
		.o_word_req     (word_req),
		.i_word_ready   (word_ready),
		.i_word_rdata   (word_rdata)
	);

	dcache_write_buffer wbuf0 (
		.i_clock        (i_clock),
		.i_rst_n        (i_rst_n),
		.i_word_request (word_request),
		.i_word_req     (word_req),
		.o_word_ready   (word_ready),
		.o_word_rdata   (word_rdata),
		.o_bus_request  (o_bus_request),
		.o_bus_req      (o_bus_req),
		.i_bus_ready    (i_bus_ready),
		.i_bus_rdata    (i_bus_rdata)
	);

endmodule

//--- tb_bus_memory.sv
// Bus memory model for the testbench with 256 words, seeded random ready and an ordered write log.
`timescale 1ns/1ps

module tb_bus_memory #(
	parameter int SEED = 32'h3023e37d
) (
	input  logic                   i_clock,
	input  logic                   i_rst_n,
	input  logic                   i_slow,        // Ready is rarely high while set.
	input  logic                   i_bus_request,
	input  mem_bus_pkg::bus_req_t  i_bus_req,
	output logic                   o_bus_ready,
	output mem_bus_pkg::bus_word_t o_bus_rdata
);
	import mem_bus_pkg::*;

	bus_word_t   mem      [256];
	bus_word_t   log_addr [128]; // Write addresses in the order the bus accepted them.
	int          log_count;
	int          seed;
	logic [7:0]  index;
	logic [31:0] rnd;

	assign index       = i_bus_req.address[9:2];
	assign o_bus_rdata = mem[index];

	// Every word starts with a distinct value built from its full index.
	initial begin
		seed = SEED;
		for (int i = 0; i < 256; i++) begin
			mem[i[7:0]] = (32'h9e37_79b9 * (i + 1)) ^ {4{i[7:0]}};
		end
	end

	always @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_bus_ready <= 1'b0;
			log_count   <= 0;
		end
		else begin
			rnd = $random(seed);
			o_bus_ready <= i_slow ? (rnd[2:0] == 3'd0) : rnd[0]; // Ready for the next cycle.
			if (i_bus_request && o_bus_ready && i_bus_req.rw) begin
				mem[index]               <= i_bus_req.wdata;
				log_addr[log_count[6:0]] <= i_bus_req.address;
				log_count                <= log_count + 1;
			end
		end
	end

endmodule

//--- tb_dmem_subsystem.sv
// Testbench top for dmem_subsystem; runs directed load/store tests against a reference memory.
`timescale 1ns/1ps
`include "dmem_consts.svh"

module tb_dmem_subsystem;
	import cpu_port_pkg::*;
	import mem_bus_pkg::*;

	// Signals carry the names of the DUT ports they drive or watch.
	logic      i_clock;
	logic      i_rst_n;
	logic      i_lsu_request;
	lsu_req_t  i_lsu_req;
	logic      o_lsu_ready;
	lsu_rsp_t  o_lsu_rsp;
	logic      o_bus_request;
	bus_req_t  o_bus_req;
	logic      i_bus_ready;
	bus_word_t i_bus_rdata;

	logic      mem_slow;
	logic      hung;           // Set by a timeout so that later accesses are skipped.
	data_t     ref_mem [256];  // Expected contents, indexed like the memory model.
	int        last_wait;      // Cycles the last access waited for ready.
	int        checks;
	int        errors;
	int        seed = 32'h3023e37d;

	always #2 i_clock = ~i_clock;

	dmem_subsystem dut0 (.*);

	tb_bus_memory mem0 (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_slow        (mem_slow),
		.i_bus_request (o_bus_request),
		.i_bus_req     (o_bus_req),
		.o_bus_ready   (i_bus_ready),
		.o_bus_rdata   (i_bus_rdata)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model of the load and store rules.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Number of bytes an access of this size covers.
	function automatic int size_bytes(access_size_e size);
		case (size)
			SIZE_BYTE: return 1;
			SIZE_HALF: return 2;
			default:   return 4;
		endcase
	endfunction

	// A store replaces only the bytes it covers, starting at its naturally aligned lane.
	function automatic data_t merge_store(data_t old, access_size_e size, addr_t addr,
			data_t wdata);
		data_t word;
		int    nbytes;
		int    first;
		word   = old;
		nbytes = size_bytes(size);
		first  = int'(addr[1:0]) - (int'(addr[1:0]) % nbytes);
		for (int i = 0; i < nbytes; i++) begin
			word[8 * (first + i) +: 8] = wdata[8 * i +: 8];
		end
		return word;
	endfunction

	// A load collects its bytes and fills the upper ones with zeros or its top bit.
	function automatic data_t load_value(data_t word, access_size_e size, addr_t addr,
			logic uns);
		data_t value;
		int    nbytes;
		int    first;
		nbytes = size_bytes(size);
		first  = int'(addr[1:0]) - (int'(addr[1:0]) % nbytes);
		value  = '0;
		for (int i = 0; i < nbytes; i++) begin
			value[8 * i +: 8] = word[8 * (first + i) +: 8];
		end
		for (int i = nbytes; i < 4; i++) begin
			value[8 * i +: 8] = uns ? 8'h00 : {8{value[8 * nbytes - 1]}};
		end
		return value;
	endfunction

	task automatic check_value(string name, data_t expected, data_t actual);
		checks++;
		assert (actual === expected) else begin
			$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// One access, held until ready. Stores update the model and loads are checked against it.
	task automatic run_access(string name, logic rw, access_size_e size, logic uns,
			addr_t addr, data_t wdata);
		int cycles;
		if (!hung) begin
			i_lsu_req     = '{rw: rw, size: size, is_unsigned: uns, address: addr, wdata: wdata};
			i_lsu_request = 1'b1;
			cycles        = 0;
			@(negedge i_clock);
			while (!o_lsu_ready && cycles < `DMEM_TIMEOUT) begin
				@(negedge i_clock);
				cycles++;
			end
			if (!o_lsu_ready) begin
				$display("Timeout: %s got no ready within %0d cycles.", name, cycles);
				errors++;
				hung = 1'b1;
			end
			else if (rw) begin
				ref_mem[addr[9:2]] = merge_store(ref_mem[addr[9:2]], size, addr, wdata);
			end
			else begin
				check_value(name, load_value(ref_mem[addr[9:2]], size, addr, uns),
					o_lsu_rsp.rdata);
			end
			last_wait = cycles;
			@(posedge i_clock);
			#1 i_lsu_request = 1'b0;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Directed tests.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic uncached_word_rw();
		int start;
		start = errors;
		run_access("uncached_rw", 1'b1, SIZE_WORD, 1'b0, 32'h8000_0010, 32'hdead_beef);
		// An uncached write reaches memory in the cycle it completes.
		check_value("uncached_rw_direct", 32'hdead_beef, mem0.mem[8'h04]);
		run_access("uncached_rw", 1'b0, SIZE_WORD, 1'b0, 32'h8000_0010, '0);
		$display("uncached_rw:    %0d errors", errors - start);
	endtask

	// Cached word writes, read back, then the bus write order and final contents.
	task automatic posted_writes(string name, int count, addr_t base, logic slow);
		int         start;
		int         log_start;
		logic [7:0] idx;
		start     = errors;
		log_start = mem0.log_count;
		mem_slow  = slow;
		for (int k = 0; k < count; k++) begin
			run_access(name, 1'b1, SIZE_WORD, 1'b0, base + 32'(4 * k), 32'h5eed_0000 + 32'(k));
			if (!slow) begin
				check_value({name, "_wait"}, '0, data_t'(last_wait)); // Posted in one cycle.
			end
		end
		mem_slow = 1'b0;
		for (int k = 0; k < count; k++) begin
			run_access(name, 1'b0, SIZE_WORD, 1'b0, base + 32'(4 * k), '0);
		end
		for (int k = 0; k < count; k++) begin
			idx = base[9:2] + 8'(k);
			check_value({name, "_log"}, base + 32'(4 * k), mem0.log_addr[7'(log_start + k)]);
			check_value({name, "_mem"}, ref_mem[idx], mem0.mem[idx]);
		end
		$display("%-15s %0d errors", {name, ":"}, errors - start);
	endtask

	task automatic subword_loads();
		int start;
		start = errors;
		run_access("subword_load", 1'b1, SIZE_WORD, 1'b0, 32'h8000_0020, 32'h8a7f_c301);
		for (int lane = 0; lane < 4; lane++) begin
			for (int u = 0; u < 2; u++) begin
				run_access("load_byte", 1'b0, SIZE_BYTE, u[0], 32'h8000_0020 + 32'(lane), '0);
				if (lane % 2 == 0) begin
					run_access("load_half", 1'b0, SIZE_HALF, u[0], 32'h8000_0020 + 32'(lane), '0);
				end
			end
		end
		$display("subword_loads:  %0d errors", errors - start);
	endtask

	// Upper store data bits are set so that a lane leak shows up in the word read.
	task automatic subword_stores();
		int    start;
		addr_t base;
		start = errors;
		for (int r = 0; r < 2; r++) begin
			base = (r == 0) ? 32'h0000_0100 : 32'h8000_0140;
			run_access("store_init", 1'b1, SIZE_WORD, 1'b0, base, 32'h1122_3344);
			for (int lane = 0; lane < 4; lane++) begin
				run_access("store_byte", 1'b1, SIZE_BYTE, 1'b0, base + 32'(lane),
					32'hffff_ff50 + 32'(lane));
				run_access("store_byte_check", 1'b0, SIZE_WORD, 1'b0, base, '0);
				if (lane % 2 == 0) begin
					run_access("store_half", 1'b1, SIZE_HALF, 1'b0, base + 32'(lane),
						32'hbeef_0a00 + 32'(lane));
					run_access("store_half_check", 1'b0, SIZE_WORD, 1'b0, base, '0);
				end
			end
		end
		$display("subword_stores: %0d errors", errors - start);
	endtask

	// Sixteen words in both regions, so cached and uncached accesses alias.
	task automatic random_mix();
		int           start;
		logic [31:0]  r;
		logic [1:0]   lane;
		access_size_e size;
		start = errors;
		for (int n = 0; n < 40; n++) begin
			r    = $random(seed);
			size = (r[2:1] == 2'd3) ? SIZE_WORD : access_size_e'(r[2:1]);
			lane = (size == SIZE_BYTE) ? r[10:9] : (size == SIZE_HALF) ? {r[10], 1'b0} : 2'b00;
			run_access("random_mix", r[0], size, r[3], {r[4], 21'b0, 4'b1000, r[8:5], lane},
				$random(seed));
		end
		$display("random_mix:     %0d errors", errors - start);
	endtask

	initial begin
		i_clock       = 1'b0;
		i_rst_n       = 1'b0;
		i_lsu_request = 1'b0;
		i_lsu_req     = '0;
		mem_slow      = 1'b0;
		hung          = 1'b0;
		last_wait     = 0;
		checks        = 0;
		errors        = 0;
		repeat (3) @(posedge i_clock);
		#1 i_rst_n = 1'b1;
		for (int i = 0; i < 256; i++) begin
			ref_mem[i[7:0]] = mem0.mem[i[7:0]];
		end
		uncached_word_rw();
		posted_writes("cached_order", 4, 32'h0000_0040, 1'b0);
		posted_writes("backpressure", 6, 32'h0000_0080, 1'b1);
		subword_loads();
		subword_stores();
		random_mix();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end
		else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+.
cpu_port_pkg.sv
mem_bus_pkg.sv
dmem_access_align.sv
dcache_write_buffer.sv
dmem_subsystem.sv
tb_bus_memory.sv
tb_dmem_subsystem.sv

//--- Makefile
sim:
	verilator --binary --timing --assert -f vlog.f --top-module tb_dmem_subsystem \
		-Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1 || echo "Test failures found" >> sim.log
	cat sim.log
	! grep -q "Test failures found" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
